/* hdl/rv_core_defines.svh */
// widths for an RV64 core whose data SRAM sees only the low 32 address bits
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// data path and register file
`define WORD_WD       64
`define GPR_ADDR_WD   5

// fetch side
`define INST_WD       32
`define PC_WD         64

// data sram
`define SRAM_ADDR_WD  32
`define SRAM_WMASK_WD 8

`endif

/* hdl/rv_core_pkg.sv */
// shared types of the pipeline; struct field widths come from the defines header
`default_nettype none

`include "rv_core_defines.svh"

package rv_core_pkg;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_LUI  // passes src2 through
  } alu_op_e;

  typedef enum logic {SRC2_RS2, SRC2_IMM} src2_sel_e;

  typedef enum logic [2:0] {
    MEM_NONE, MEM_LD, MEM_LW, MEM_LBU, MEM_SD, MEM_SW, MEM_SB
  } mem_op_e;

  typedef struct packed {
    logic [`PC_WD-1:0]       pc;
    logic [`WORD_WD-1:0]     rs1_data;
    logic [`WORD_WD-1:0]     rs2_data;
    logic [`WORD_WD-1:0]     imm;
    alu_op_e                 alu_op;
    src2_sel_e               src2_sel;
    logic                    word_cut;  // sign-extend low word
    mem_op_e                 mem_op;
    logic [`GPR_ADDR_WD-1:0] rd;
    logic                    gpr_we;
    logic                    ebreak;
    logic                    invalid;
  } id_to_ex_t;

  typedef struct packed {
    logic [`PC_WD-1:0]       pc;
    logic [`WORD_WD-1:0]     alu_result;
    logic [`GPR_ADDR_WD-1:0] rd;
    logic                    gpr_we;
    mem_op_e                 mem_op;
    logic                    ebreak;
    logic                    invalid;
  } ex_to_wb_t;

endpackage

`default_nettype wire

/* hdl/pipe_slot.sv */
// one pipeline register with valid bit; the payload itself has no reset
`default_nettype none

module pipe_slot #(
  parameter type payload_t = logic
) (
  input  wire      i_clk,
  input  wire      i_rst,
  input  wire      i_valid,
  input  payload_t i_payload,
  input  wire      i_ready_go,      // this stage done with its item
  input  wire      i_next_allowin,
  output logic     o_allowin,
  output logic     o_valid,         // valid toward next stage
  output payload_t o_payload
);

  logic     valid_q;
  payload_t payload_q;

  assign o_allowin = !valid_q || (i_ready_go && i_next_allowin);
  assign o_valid   = valid_q && i_ready_go;
  assign o_payload = payload_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q <= 1'b0;
    end else if (o_allowin) begin
      valid_q <= i_valid;  // drops when item leaves and nothing arrives
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid && o_allowin) begin
      payload_q <= i_payload;
    end
  end

endmodule

`default_nettype wire

/* hdl/gpr_file.sv */
// 32 x 64 register file with x0 tied to zero and the write port bypassed to both reads
`default_nettype none

`include "rv_core_defines.svh"

module gpr_file (
  input  wire                    i_clk,
  input  wire                    i_rst,
  input  wire [`GPR_ADDR_WD-1:0] i_rs1,
  input  wire [`GPR_ADDR_WD-1:0] i_rs2,
  output logic [`WORD_WD-1:0]    o_rs1_data,
  output logic [`WORD_WD-1:0]    o_rs2_data,
  input  wire                    i_we,
  input  wire [`GPR_ADDR_WD-1:0] i_waddr,
  input  wire [`WORD_WD-1:0]     i_wdata
);

  logic [`WORD_WD-1:0] regs [32];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // write-first
  assign o_rs1_data = (i_rs1 == '0) ? '0 :
                      (i_we && (i_waddr == i_rs1)) ? i_wdata : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 :
                      (i_we && (i_waddr == i_rs2)) ? i_wdata : regs[i_rs2];

endmodule

`default_nettype wire

/* hdl/id_stage.sv */
// decode for the RV64I subset; no forwarding so any RAW on ex or wb stalls here
`default_nettype none

`include "rv_core_defines.svh"

module id_stage import rv_core_pkg::*; (
  input  wire                     i_clk,
  input  wire                     i_rst,
  input  wire                     i_inst_valid,
  input  wire [`INST_WD-1:0]      i_inst,
  input  wire [`PC_WD-1:0]        i_pc,
  output logic                    o_inst_allowin,
  input  wire                     i_ex_allowin,
  input  wire [`GPR_ADDR_WD-1:0]  i_ex_busy_rd,
  input  wire                     i_ex_busy_we,
  input  wire [`GPR_ADDR_WD-1:0]  i_wb_busy_rd,
  input  wire                     i_wb_busy_we,
  output logic [`GPR_ADDR_WD-1:0] o_rs1,
  output logic [`GPR_ADDR_WD-1:0] o_rs2,
  input  wire [`WORD_WD-1:0]      i_rs1_data,
  input  wire [`WORD_WD-1:0]      i_rs2_data,
  output logic                    o_id_to_ex_valid,
  output id_to_ex_t               o_id_to_ex
);

  logic                ds_valid;
  logic [`INST_WD-1:0] inst;
  logic [`PC_WD-1:0]   pc;
  logic                ready_go;
  logic                use_rs1;
  logic                use_rs2;
  logic                rs1_hit;
  logic                rs2_hit;
  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;

  assign o_inst_allowin   = !ds_valid || (ready_go && i_ex_allowin);
  assign o_id_to_ex_valid = ds_valid && ready_go;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_inst_allowin) begin
      ds_valid <= i_inst_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_inst_valid && o_inst_allowin) begin
      inst <= i_inst;
      pc   <= i_pc;
    end
  end

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign o_rs1  = inst[19:15];
  assign o_rs2  = inst[24:20];

  // OP, OP-IMM, OP-32, OP-IMM-32, LOAD, STORE read rs1
  assign use_rs1 = (opcode == 7'h33) || (opcode == 7'h13) || (opcode == 7'h3b) ||
                   (opcode == 7'h1b) || (opcode == 7'h03) || (opcode == 7'h23);
  assign use_rs2 = (opcode == 7'h33) || (opcode == 7'h3b) || (opcode == 7'h23);

  assign rs1_hit = use_rs1 && (o_rs1 != '0) &&
                   ((i_ex_busy_we && (i_ex_busy_rd == o_rs1)) ||
                    (i_wb_busy_we && (i_wb_busy_rd == o_rs1)));
  assign rs2_hit = use_rs2 && (o_rs2 != '0) &&
                   ((i_ex_busy_we && (i_ex_busy_rd == o_rs2)) ||
                    (i_wb_busy_we && (i_wb_busy_rd == o_rs2)));
  assign ready_go = !(rs1_hit || rs2_hit);

  always_comb begin
    o_id_to_ex          = '0;
    o_id_to_ex.pc       = pc;
    o_id_to_ex.rs1_data = i_rs1_data;
    o_id_to_ex.rs2_data = i_rs2_data;
    o_id_to_ex.imm      = {{52{inst[31]}}, inst[31:20]};  // I-type by default
    o_id_to_ex.alu_op   = ALU_ADD;
    o_id_to_ex.src2_sel = SRC2_IMM;
    o_id_to_ex.mem_op   = MEM_NONE;
    o_id_to_ex.rd       = inst[11:7];
    case (opcode)
      7'h33: begin  // OP
        o_id_to_ex.src2_sel = SRC2_RS2;
        o_id_to_ex.gpr_we   = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: o_id_to_ex.alu_op = ALU_ADD;
          10'b0100000_000: o_id_to_ex.alu_op = ALU_SUB;
          10'b0000000_001: o_id_to_ex.alu_op = ALU_SLL;
          10'b0000000_010: o_id_to_ex.alu_op = ALU_SLT;
          10'b0000000_100: o_id_to_ex.alu_op = ALU_XOR;
          10'b0000000_101: o_id_to_ex.alu_op = ALU_SRL;
          10'b0100000_101: o_id_to_ex.alu_op = ALU_SRA;
          10'b0000000_110: o_id_to_ex.alu_op = ALU_OR;
          10'b0000000_111: o_id_to_ex.alu_op = ALU_AND;
          default: begin
            o_id_to_ex.gpr_we  = 1'b0;
            o_id_to_ex.invalid = 1'b1;
          end
        endcase
      end
      7'h13, 7'h1b: begin  // ADDI / ADDIW
        o_id_to_ex.gpr_we   = (funct3 == 3'b000);
        o_id_to_ex.invalid  = (funct3 != 3'b000);
        o_id_to_ex.word_cut = opcode[3];
      end
      7'h3b: begin  // ADDW
        o_id_to_ex.src2_sel = SRC2_RS2;
        o_id_to_ex.word_cut = 1'b1;
        o_id_to_ex.gpr_we   = ({funct7, funct3} == 10'b0);
        o_id_to_ex.invalid  = ({funct7, funct3} != 10'b0);
      end
      7'h37: begin  // LUI
        o_id_to_ex.imm    = {{32{inst[31]}}, inst[31:12], 12'b0};
        o_id_to_ex.alu_op = ALU_LUI;
        o_id_to_ex.gpr_we = 1'b1;
      end
      7'h03: begin
        o_id_to_ex.gpr_we = 1'b1;
        case (funct3)
          3'b011:  o_id_to_ex.mem_op = MEM_LD;
          3'b010:  o_id_to_ex.mem_op = MEM_LW;
          3'b100:  o_id_to_ex.mem_op = MEM_LBU;
          default: begin
            o_id_to_ex.gpr_we  = 1'b0;
            o_id_to_ex.invalid = 1'b1;
          end
        endcase
      end
      7'h23: begin
        o_id_to_ex.imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};  // S-type
        case (funct3)
          3'b011:  o_id_to_ex.mem_op = MEM_SD;
          3'b010:  o_id_to_ex.mem_op = MEM_SW;
          3'b000:  o_id_to_ex.mem_op = MEM_SB;
          default: o_id_to_ex.invalid = 1'b1;
        endcase
      end
      7'h73: begin
        o_id_to_ex.ebreak  = (inst == 32'h0010_0073);
        o_id_to_ex.invalid = (inst != 32'h0010_0073);
      end
      default: o_id_to_ex.invalid = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/ex_stage.sv */
// ALU and data SRAM request; addresses are taken as aligned to the access size
`default_nettype none

`include "rv_core_defines.svh"

module ex_stage import rv_core_pkg::*; (
  input  wire                      i_clk,
  input  wire                      i_rst,
  input  wire                      i_id_to_ex_valid,
  input  id_to_ex_t                i_id_to_ex,
  output logic                     o_ex_allowin,
  output logic [`GPR_ADDR_WD-1:0]  o_ex_busy_rd,
  output logic                     o_ex_busy_we,
  output logic                     o_ex_to_wb_valid,
  output ex_to_wb_t                o_ex_to_wb,
  input  wire                      i_wb_allowin,
  output logic [`SRAM_ADDR_WD-1:0] o_data_sram_addr,
  output logic                     o_data_sram_ren,
  output logic                     o_data_sram_wen,
  output logic [`SRAM_WMASK_WD-1:0] o_data_sram_wmask,
  output logic [`WORD_WD-1:0]      o_data_sram_wdata
);

  id_to_ex_t           es;
  logic [`WORD_WD-1:0] src2;
  logic [`WORD_WD-1:0] alu_raw;
  logic [`WORD_WD-1:0] alu_result;
  logic [2:0]          offset;
  logic                is_load;
  logic                is_store;

  pipe_slot #(
    .payload_t     (id_to_ex_t)
  ) u_slot (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_valid       (i_id_to_ex_valid),
    .i_payload     (i_id_to_ex),
    .i_ready_go    (1'b1),  // single-cycle ALU
    .i_next_allowin(i_wb_allowin),
    .o_allowin     (o_ex_allowin),
    .o_valid       (o_ex_to_wb_valid),
    .o_payload     (es)
  );

  assign o_ex_busy_rd = es.rd;
  assign o_ex_busy_we = o_ex_to_wb_valid && es.gpr_we;

  assign src2 = (es.src2_sel == SRC2_IMM) ? es.imm : es.rs2_data;

  always_comb begin
    case (es.alu_op)
      ALU_SUB: alu_raw = es.rs1_data - src2;
      ALU_AND: alu_raw = es.rs1_data & src2;
      ALU_OR:  alu_raw = es.rs1_data | src2;
      ALU_XOR: alu_raw = es.rs1_data ^ src2;
      ALU_SLT: alu_raw = {63'b0, $signed(es.rs1_data) < $signed(src2)};
      ALU_SLL: alu_raw = es.rs1_data << src2[5:0];
      ALU_SRL: alu_raw = es.rs1_data >> src2[5:0];
      ALU_SRA: alu_raw = $signed(es.rs1_data) >>> src2[5:0];
      ALU_LUI: alu_raw = src2;
      default: alu_raw = es.rs1_data + src2;  // also load/store address
    endcase
  end

  assign alu_result = es.word_cut ? {{32{alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

  // store alignment
  assign offset   = alu_result[2:0];
  assign is_load  = (es.mem_op == MEM_LD) || (es.mem_op == MEM_LW) || (es.mem_op == MEM_LBU);
  assign is_store = (es.mem_op == MEM_SD) || (es.mem_op == MEM_SW) || (es.mem_op == MEM_SB);

  always_comb begin
    case (es.mem_op)
      MEM_SD:  o_data_sram_wmask = 8'hff;
      MEM_SW:  o_data_sram_wmask = alu_result[2] ? 8'hf0 : 8'h0f;
      MEM_SB:  o_data_sram_wmask = 8'h01 << offset;
      default: o_data_sram_wmask = 8'h00;
    endcase
  end

  assign o_data_sram_wdata = es.rs2_data << {offset, 3'b000};
  assign o_data_sram_addr  = alu_result[`SRAM_ADDR_WD-1:0];
  assign o_data_sram_ren   = o_ex_to_wb_valid && is_load;
  assign o_data_sram_wen   = o_ex_to_wb_valid && is_store;

  assign o_ex_to_wb.pc         = es.pc;
  assign o_ex_to_wb.alu_result = alu_result;
  assign o_ex_to_wb.rd         = es.rd;
  assign o_ex_to_wb.gpr_we     = es.gpr_we;
  assign o_ex_to_wb.mem_op     = es.mem_op;
  assign o_ex_to_wb.ebreak     = es.ebreak;
  assign o_ex_to_wb.invalid    = es.invalid;

endmodule

`default_nettype wire

/* hdl/wb_stage.sv */
// result stage never stalls so the load data of the previous cycle is always taken
`default_nettype none

`include "rv_core_defines.svh"

module wb_stage import rv_core_pkg::*; (
  input  wire                     i_clk,
  input  wire                     i_rst,
  input  wire                     i_ex_to_wb_valid,
  input  ex_to_wb_t               i_ex_to_wb,
  output logic                    o_wb_allowin,
  output logic [`GPR_ADDR_WD-1:0] o_wb_busy_rd,
  output logic                    o_wb_busy_we,
  input  wire [`WORD_WD-1:0]      i_data_sram_rdata,
  output logic                    o_gpr_we,
  output logic [`GPR_ADDR_WD-1:0] o_gpr_waddr,
  output logic [`WORD_WD-1:0]     o_gpr_wdata,
  output logic                    o_commit_valid,
  output logic [`PC_WD-1:0]       o_commit_pc,
  output logic [`GPR_ADDR_WD-1:0] o_commit_rd,
  output logic [`WORD_WD-1:0]     o_commit_wdata,
  output logic                    o_ebreak,
  output logic                    o_invalid
);

  ex_to_wb_t           ws;
  logic [`WORD_WD-1:0] rdata_sh;
  logic [`WORD_WD-1:0] wdata;

  pipe_slot #(
    .payload_t     (ex_to_wb_t)
  ) u_slot (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_valid       (i_ex_to_wb_valid),
    .i_payload     (i_ex_to_wb),
    .i_ready_go    (1'b1),
    .i_next_allowin(1'b1),  // commit always drains
    .o_allowin     (o_wb_allowin),
    .o_valid       (o_commit_valid),
    .o_payload     (ws)
  );

  assign o_wb_busy_rd = ws.rd;
  assign o_wb_busy_we = o_commit_valid && ws.gpr_we;

  // addressed bytes down to bit 0
  assign rdata_sh = i_data_sram_rdata >> {ws.alu_result[2:0], 3'b000};

  always_comb begin
    case (ws.mem_op)
      MEM_LD:  wdata = i_data_sram_rdata;
      MEM_LW:  wdata = {{32{rdata_sh[31]}}, rdata_sh[31:0]};
      MEM_LBU: wdata = {56'b0, rdata_sh[7:0]};
      default: wdata = ws.alu_result;
    endcase
  end

  assign o_gpr_we       = o_commit_valid && ws.gpr_we && (ws.rd != '0);
  assign o_gpr_waddr    = ws.rd;
  assign o_gpr_wdata    = wdata;
  assign o_commit_pc    = ws.pc;
  assign o_commit_rd    = ws.rd;
  assign o_commit_wdata = wdata;
  assign o_ebreak       = o_commit_valid && ws.ebreak;
  assign o_invalid      = o_commit_valid && ws.invalid;

endmodule

`default_nettype wire

/* hdl/rv_core_top.sv */
// three-stage RV64I subset core; fetch and data SRAM live outside
`default_nettype none

`include "rv_core_defines.svh"

module rv_core_top import rv_core_pkg::*; (
  input  wire                       i_clk,
  input  wire                       i_rst,
  // fetch
  input  wire                       i_inst_valid,
  input  wire [`INST_WD-1:0]        i_inst,
  input  wire [`PC_WD-1:0]          i_pc,
  output logic                      o_inst_allowin,
  // data sram
  output logic [`SRAM_ADDR_WD-1:0]  o_data_sram_addr,
  output logic                      o_data_sram_ren,
  output logic                      o_data_sram_wen,
  output logic [`SRAM_WMASK_WD-1:0] o_data_sram_wmask,
  output logic [`WORD_WD-1:0]       o_data_sram_wdata,
  input  wire [`WORD_WD-1:0]        i_data_sram_rdata,
  // commit report
  output logic                      o_commit_valid,
  output logic [`PC_WD-1:0]         o_commit_pc,
  output logic [`GPR_ADDR_WD-1:0]   o_commit_rd,
  output logic [`WORD_WD-1:0]       o_commit_wdata,
  output logic                      o_ebreak,
  output logic                      o_invalid
);

  logic                    ex_allowin;
  logic                    wb_allowin;
  logic                    id_to_ex_valid;
  id_to_ex_t               id_to_ex;
  logic                    ex_to_wb_valid;
  ex_to_wb_t               ex_to_wb;
  logic [`GPR_ADDR_WD-1:0] ex_busy_rd;
  logic                    ex_busy_we;
  logic [`GPR_ADDR_WD-1:0] wb_busy_rd;
  logic                    wb_busy_we;
  logic [`GPR_ADDR_WD-1:0] rs1;
  logic [`GPR_ADDR_WD-1:0] rs2;
  logic [`WORD_WD-1:0]     rs1_data;
  logic [`WORD_WD-1:0]     rs2_data;
  logic                    gpr_we;
  logic [`GPR_ADDR_WD-1:0] gpr_waddr;
  logic [`WORD_WD-1:0]     gpr_wdata;

  id_stage u_id (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_inst_valid     (i_inst_valid),
    .i_inst           (i_inst),
    .i_pc             (i_pc),
    .o_inst_allowin   (o_inst_allowin),
    .i_ex_allowin     (ex_allowin),
    .i_ex_busy_rd     (ex_busy_rd),
    .i_ex_busy_we     (ex_busy_we),
    .i_wb_busy_rd     (wb_busy_rd),
    .i_wb_busy_we     (wb_busy_we),
    .o_rs1            (rs1),
    .o_rs2            (rs2),
    .i_rs1_data       (rs1_data),
    .i_rs2_data       (rs2_data),
    .o_id_to_ex_valid (id_to_ex_valid),
    .o_id_to_ex       (id_to_ex)
  );

  gpr_file u_gpr (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_we       (gpr_we),
    .i_waddr    (gpr_waddr),
    .i_wdata    (gpr_wdata)
  );

  ex_stage u_ex (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_id_to_ex_valid  (id_to_ex_valid),
    .i_id_to_ex        (id_to_ex),
    .o_ex_allowin      (ex_allowin),
    .o_ex_busy_rd      (ex_busy_rd),
    .o_ex_busy_we      (ex_busy_we),
    .o_ex_to_wb_valid  (ex_to_wb_valid),
    .o_ex_to_wb        (ex_to_wb),
    .i_wb_allowin      (wb_allowin),
    .o_data_sram_addr  (o_data_sram_addr),
    .o_data_sram_ren   (o_data_sram_ren),
    .o_data_sram_wen   (o_data_sram_wen),
    .o_data_sram_wmask (o_data_sram_wmask),
    .o_data_sram_wdata (o_data_sram_wdata)
  );

  wb_stage u_wb (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_ex_to_wb_valid  (ex_to_wb_valid),
    .i_ex_to_wb        (ex_to_wb),
    .o_wb_allowin      (wb_allowin),
    .o_wb_busy_rd      (wb_busy_rd),
    .o_wb_busy_we      (wb_busy_we),
    .i_data_sram_rdata (i_data_sram_rdata),
    .o_gpr_we          (gpr_we),
    .o_gpr_waddr       (gpr_waddr),
    .o_gpr_wdata       (gpr_wdata),
    .o_commit_valid    (o_commit_valid),
    .o_commit_pc       (o_commit_pc),
    .o_commit_rd       (o_commit_rd),
    .o_commit_wdata    (o_commit_wdata),
    .o_ebreak          (o_ebreak),
    .o_invalid         (o_invalid)
  );

endmodule

`default_nettype wire

/* test/tb_data_sram.sv */
// data memory of 256 doublewords picked by address bits 10:3 only; read data lags one cycle
`default_nettype none

`include "rv_core_defines.svh"

module tb_data_sram (
  input  wire                      i_clk,
  input  wire [`SRAM_ADDR_WD-1:0]  i_addr,
  input  wire                      i_ren,
  input  wire                      i_wen,
  input  wire [`SRAM_WMASK_WD-1:0] i_wmask,
  input  wire [`WORD_WD-1:0]       i_wdata,
  output logic [`WORD_WD-1:0]      o_rdata
);

  logic [`WORD_WD-1:0] mem [256];
  logic [7:0]          idx;

  assign idx = i_addr[10:3];

  // pattern follows the whole index so a wrong word shows up
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {32'(i) * 32'h9e37_79b9, 32'(i) ^ 32'hc3c3_5a5a};
    end
  end

  always @(posedge i_clk) begin
    if (i_wen) begin
      for (int b = 0; b < 8; b++) begin
        if (i_wmask[b]) begin
          mem[idx][b*8 +: 8] <= i_wdata[b*8 +: 8];  // byte lanes
        end
      end
    end
    if (i_ren) begin
      o_rdata <= mem[idx];
    end
  end

endmodule

`default_nettype wire

/* test/tb_rv_core.sv */
// seeded random RV64I program; data addresses stay inside the 256-doubleword memory model
`default_nettype none

`include "rv_core_defines.svh"

module tb_rv_core;

  localparam int RST_CYC = 4;
  localparam int N_MAX   = 128;

  typedef enum {R_ADD, R_SUB, R_AND, R_OR, R_XOR, R_SLT, R_SLL, R_SRL, R_SRA, R_ADDW} r_op_e;

  logic                      clk = 1'b0;
  logic                      rst = 1'b1;
  logic                      inst_valid = 1'b0;
  logic [`INST_WD-1:0]       inst = '0;
  logic [`PC_WD-1:0]         pc = '0;
  logic                      inst_allowin;
  logic [`SRAM_ADDR_WD-1:0]  sram_addr;
  logic                      sram_ren;
  logic                      sram_wen;
  logic [`SRAM_WMASK_WD-1:0] sram_wmask;
  logic [`WORD_WD-1:0]       sram_wdata;
  logic [`WORD_WD-1:0]       sram_rdata;
  logic                      commit_valid;
  logic [`PC_WD-1:0]         commit_pc;
  logic [`GPR_ADDR_WD-1:0]   commit_rd;
  logic [`WORD_WD-1:0]       commit_wdata;
  logic                      ebreak;
  logic                      invalid;

  // program and expected results built in program order before reset ends
  logic [31:0] prog      [N_MAX];
  logic [63:0] exp_pc    [N_MAX];
  logic [4:0]  exp_rd    [N_MAX];
  logic        exp_we    [N_MAX];
  logic [63:0] exp_wdata [N_MAX];
  logic        exp_brk   [N_MAX];
  logic        exp_inv   [N_MAX];
  logic [31:0] st_addr   [N_MAX];
  logic [7:0]  st_mask   [N_MAX];
  logic [63:0] st_data   [N_MAX];
  logic [31:0] ld_addr   [N_MAX];
  logic [63:0] ref_gpr   [32];
  logic [63:0] ref_mem   [256];
  logic [31:0] rng = 32'd82819;
  int          n_inst = 0;
  int          n_st = 0;
  int          n_ld = 0;
  int          commit_idx = 0;
  int          st_idx = 0;
  int          ld_idx = 0;
  int          stalls = 0;
  int          cycles = 0;
  int          errors = 0;

  always #2 clk = ~clk;

  rv_core_top dut_i (
    .i_clk             (clk),
    .i_rst             (rst),
    .i_inst_valid      (inst_valid),
    .i_inst            (inst),
    .i_pc              (pc),
    .o_inst_allowin    (inst_allowin),
    .o_data_sram_addr  (sram_addr),
    .o_data_sram_ren   (sram_ren),
    .o_data_sram_wen   (sram_wen),
    .o_data_sram_wmask (sram_wmask),
    .o_data_sram_wdata (sram_wdata),
    .i_data_sram_rdata (sram_rdata),
    .o_commit_valid    (commit_valid),
    .o_commit_pc       (commit_pc),
    .o_commit_rd       (commit_rd),
    .o_commit_wdata    (commit_wdata),
    .o_ebreak          (ebreak),
    .o_invalid         (invalid)
  );

  tb_data_sram mem_i (
    .i_clk   (clk),
    .i_addr  (sram_addr),
    .i_ren   (sram_ren),
    .i_wen   (sram_wen),
    .i_wmask (sram_wmask),
    .i_wdata (sram_wdata),
    .o_rdata (sram_rdata)
  );

  function automatic logic [31:0] next_rand();  // xorshift32
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [63:0] fill_word(input int idx);
    return {32'(idx) * 32'h9e37_79b9, 32'(idx) ^ 32'hc3c3_5a5a};
  endfunction

  function automatic logic [63:0] sext32(input logic [63:0] v);
    return {{32{v[31]}}, v[31:0]};
  endfunction

  function automatic logic [63:0] sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  // base-relative offset aligned to 1, 4 or 8 bytes
  function automatic logic [11:0] aligned_off(input logic [31:0] v, input int sz);
    logic [2:0] low;
    low = (sz == 0) ? v[18:16] : (sz == 1) ? {v[18], 2'b00} : 3'b000;
    return {3'b000, v[13:8], low};
  endfunction

  task automatic record_inst(input logic [31:0] code, input logic [4:0] rd, input logic we,
                             input logic [63:0] val, input logic brk, input logic inv);
    prog[n_inst]      = code;
    exp_pc[n_inst]    = 64'h1000 + 64'(n_inst) * 64'd4;
    exp_rd[n_inst]    = rd;
    exp_we[n_inst]    = we;
    exp_wdata[n_inst] = val;
    exp_brk[n_inst]   = brk;
    exp_inv[n_inst]   = inv;
    if (we && rd != 5'd0) begin
      ref_gpr[rd] = val;
    end
    n_inst++;
  endtask

  task automatic emit_r(input r_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [4:0] rs2);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    logic [6:0]  f7;
    logic [2:0]  f3;
    a = ref_gpr[rs1];
    b = ref_gpr[rs2];
    case (op)
      R_SUB:   {f7, f3, r} = {7'h20, 3'd0, a - b};
      R_AND:   {f7, f3, r} = {7'h00, 3'd7, a & b};
      R_OR:    {f7, f3, r} = {7'h00, 3'd6, a | b};
      R_XOR:   {f7, f3, r} = {7'h00, 3'd4, a ^ b};
      R_SLT:   {f7, f3, r} = {7'h00, 3'd2, 63'd0, $signed(a) < $signed(b)};
      R_SLL:   {f7, f3, r} = {7'h00, 3'd1, a << b[5:0]};
      R_SRL:   {f7, f3, r} = {7'h00, 3'd5, a >> b[5:0]};
      R_SRA:   {f7, f3, r} = {7'h20, 3'd5, $signed(a) >>> b[5:0]};
      R_ADDW:  {f7, f3, r} = {7'h00, 3'd0, sext32(a + b)};
      default: {f7, f3, r} = {7'h00, 3'd0, a + b};
    endcase
    record_inst({f7, rs2, rs1, f3, rd, (op == R_ADDW) ? 7'h3b : 7'h33}, rd, 1'b1, r,
                1'b0, 1'b0);
  endtask

  task automatic emit_i(input logic word, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [11:0] imm);
    logic [63:0] r;
    r = ref_gpr[rs1] + sext12(imm);
    if (word) begin
      r = sext32(r);
    end
    record_inst({imm, rs1, 3'd0, rd, word ? 7'h1b : 7'h13}, rd, 1'b1, r, 1'b0, 1'b0);
  endtask

  task automatic emit_lui(input logic [4:0] rd, input logic [19:0] imm20);
    record_inst({imm20, rd, 7'h37}, rd, 1'b1, {{32{imm20[19]}}, imm20, 12'h000}, 1'b0, 1'b0);
  endtask

  // sz 0 LBU, 1 LW, 2 LD
  task automatic emit_load(input int sz, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [11:0] imm);
    logic [63:0] addr;
    logic [63:0] w;
    logic [63:0] sh;
    logic [63:0] r;
    logic [2:0]  f3;
    addr = ref_gpr[rs1] + sext12(imm);
    w    = ref_mem[addr[10:3]];
    sh   = w >> {addr[2:0], 3'b000};
    case (sz)
      0:       {f3, r} = {3'd4, 56'd0, sh[7:0]};
      1:       {f3, r} = {3'd2, sext32(sh)};
      default: {f3, r} = {3'd3, w};
    endcase
    ld_addr[n_ld] = addr[31:0];
    n_ld++;
    record_inst({imm, rs1, f3, rd, 7'h03}, rd, 1'b1, r, 1'b0, 1'b0);
  endtask

  // sz 0 SB, 1 SW, 2 SD
  task automatic emit_store(input int sz, input logic [4:0] rs2, input logic [4:0] rs1,
                            input logic [11:0] imm);
    logic [63:0] addr;
    logic [63:0] d;
    logic [7:0]  m;
    logic [2:0]  f3;
    addr = ref_gpr[rs1] + sext12(imm);
    case (sz)
      0:       {f3, m} = {3'd0, 8'h01 << addr[2:0]};
      1:       {f3, m} = {3'd2, addr[2] ? 8'hf0 : 8'h0f};
      default: {f3, m} = {3'd3, 8'hff};
    endcase
    d = ref_gpr[rs2] << {addr[2:0], 3'b000};
    st_addr[n_st] = addr[31:0];
    st_mask[n_st] = m;
    st_data[n_st] = d;
    n_st++;
    for (int b = 0; b < 8; b++) begin
      if (m[b]) begin
        ref_mem[addr[10:3]][b*8 +: 8] = d[b*8 +: 8];
      end
    end
    record_inst({imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23}, imm[4:0], 1'b0, 64'd0, 1'b0, 1'b0);
  endtask

  task automatic build_program();
    logic [31:0] v;
    for (int r = 1; r < 8; r++) begin  // each ADDI waits on its LUI
      v = next_rand();
      emit_lui(5'(r), v[31:12]);
      emit_i(1'b0, 5'(r), 5'(r), v[11:0]);
    end
    for (int k = 0; k < 12; k++) begin
      v = next_rand();
      emit_r(r_op_e'(v % 10), 5'(1 + v[7:4] % 15), 5'(v[11:8]), 5'(v[15:12]));
    end
    emit_lui(5'd9, 20'h7ffff);
    emit_i(1'b0, 5'd9, 5'd9, 12'h7ff);
    emit_r(R_ADDW, 5'd10, 5'd9, 5'd9);
    emit_i(1'b1, 5'd11, 5'd9, 12'h7ff);
    emit_i(1'b1, 5'd11, 5'd11, 12'h7ff);  // carries into bit 31
    emit_i(1'b0, 5'd12, 5'd0, 12'h100);   // data base
    emit_store(2, 5'd1, 5'd12, 12'h000);
    emit_store(1, 5'd2, 5'd12, 12'h00c);
    emit_store(1, 5'd3, 5'd12, 12'h010);
    emit_store(0, 5'd4, 5'd12, 12'h01b);
    for (int k = 0; k < 6; k++) begin
      v = next_rand();
      emit_store(int'(v % 3), 5'(v[7:4]), 5'd12, aligned_off(v, int'(v % 3)));
    end
    emit_load(2, 5'd13, 5'd12, 12'h000);
    emit_load(1, 5'd14, 5'd12, 12'h00c);
    emit_load(0, 5'd15, 5'd12, 12'h01b);
    emit_load(1, 5'd13, 5'd12, 12'h204);  // never stored
    for (int k = 0; k < 6; k++) begin
      v = next_rand();
      emit_load(int'(v % 3), 5'(13 + v[5:4] % 3), 5'd12, aligned_off(v, int'(v % 3)));
    end
    emit_r(R_ADD, 5'd5, 5'd13, 5'd14);
    record_inst(32'h0010_0073, 5'd0, 1'b0, 64'd0, 1'b1, 1'b0);  // ebreak
    record_inst({7'h01, 5'd2, 5'd1, 3'd0, 5'd5, 7'h33}, 5'd5, 1'b0, 64'd0, 1'b0, 1'b1);  // mul
    emit_r(R_XOR, 5'd6, 5'd5, 5'd0);  // x5 must be untouched
  endtask

  task automatic report_mismatch(input string what);
    errors++;
    $display("[FAIL] %0t: %s (commit %0d pc %h rd %0d data %h, store %0d)", $time, what,
             commit_idx, commit_pc, commit_rd, commit_wdata, st_idx);
  endtask

  task automatic send_inst(input int idx);
    logic taken;
    inst_valid = 1'b1;
    inst       = prog[idx];
    pc         = exp_pc[idx];
    taken      = 1'b0;
    while (!taken) begin
      taken = inst_allowin;  // only registered state feeds allowin
      @(posedge clk);
      #1;
    end
  endtask

  assert property (@(posedge clk) $fell(rst) |->
                   !commit_valid && !sram_ren && !sram_wen && inst_allowin)
    else report_mismatch("outputs right after reset");

  assert property (@(posedge clk) disable iff (rst) commit_valid |->
                   commit_idx < n_inst && commit_pc == exp_pc[commit_idx] &&
                   commit_rd == exp_rd[commit_idx])
    else report_mismatch("commit pc or rd");

  assert property (@(posedge clk) disable iff (rst) commit_valid && exp_we[commit_idx] |->
                   commit_wdata == exp_wdata[commit_idx])
    else report_mismatch("commit write data");

  assert property (@(posedge clk) disable iff (rst) commit_valid |->
                   ebreak == exp_brk[commit_idx] && invalid == exp_inv[commit_idx])
    else report_mismatch("ebreak or invalid flag");

  assert property (@(posedge clk) disable iff (rst) sram_wen |->
                   st_idx < n_st && sram_addr == st_addr[st_idx] &&
                   sram_wmask == st_mask[st_idx] && sram_wdata == st_data[st_idx])
    else report_mismatch("store request");

  assert property (@(posedge clk) disable iff (rst) sram_ren |->
                   ld_idx < n_ld && sram_addr == ld_addr[ld_idx])
    else report_mismatch("load request");

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (!rst && commit_valid) begin
      commit_idx <= commit_idx + 1;
    end
    if (!rst && sram_wen) begin
      st_idx <= st_idx + 1;
    end
    if (!rst && sram_ren) begin
      ld_idx <= ld_idx + 1;
    end
    if (!rst && !inst_allowin) begin
      stalls <= stalls + 1;
    end
    if (cycles > 10 * n_inst + RST_CYC) begin
      $display("timeout: %0d of %0d instructions committed after %0d cycles, %0d errors",
               commit_idx, n_inst, cycles, errors);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    for (int i = 0; i < 32; i++) begin
      ref_gpr[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = fill_word(i);
    end
    build_program();
    repeat (RST_CYC) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < n_inst; i++) begin
      send_inst(i);
    end
    inst_valid = 1'b0;
    while (commit_idx < n_inst) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    assert (stalls > 0) else begin
      errors++;
      $display("decode never stalled on the dependent chain");
    end
    assert (st_idx == n_st && ld_idx == n_ld) else begin
      errors++;
      $display("saw %0d store and %0d load requests but the program has %0d and %0d",
               st_idx, ld_idx, n_st, n_ld);
    end
    $display("errors: %0d  commits: %0d/%0d  stores: %0d/%0d  loads: %0d/%0d  stall cycles: %0d",
             errors, commit_idx, n_inst, st_idx, n_st, ld_idx, n_ld, stalls);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/pipe_slot.sv
hdl/gpr_file.sv
hdl/id_stage.sv
hdl/ex_stage.sv
hdl/wb_stage.sv
hdl/rv_core_top.sv
test/tb_data_sram.sv
test/tb_rv_core.sv

/* Makefile */
SIM      := verilator
TOP      := tb_rv_core
FILELIST := build.f
FLAGS    := --binary --timing --assert -j 0
LINT     := --lint-only --timing -Wall
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
